//--- source/rename_cfg_pkg.sv
// widths, counts and register number types of the rename stage
`default_nettype none

package rename_cfg_pkg;

    localparam int unsigned NUM_ARCH_REGS = 32;
    localparam int unsigned NUM_PHYS_REGS = 80;
    localparam int unsigned BUNDLE_WIDTH  = 4;
    localparam int unsigned RELEASE_WIDTH = 2;

    // architectural register number, x0 renamed like the rest
    typedef logic [$clog2(NUM_ARCH_REGS)-1:0] arch_reg_t;

    typedef logic [$clog2(NUM_PHYS_REGS)-1:0] phys_reg_t;

    // position of an instruction inside a bundle
    typedef logic [$clog2(BUNDLE_WIDTH)-1:0] slot_t;

    // must hold the full count of physical registers
    typedef logic [$clog2(NUM_PHYS_REGS+1)-1:0] free_count_t;

endpackage

`default_nettype wire

//--- source/rename_bundle_pkg.sv
// request, result and override select structs of the rename stage
`default_nettype none

package rename_bundle_pkg;

    import rename_cfg_pkg::*;

    // one decoded instruction entering rename
    typedef struct packed {
        logic      valid;
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t rd;
        logic      write_rd;
    } rename_req_t;

    // one renamed instruction toward dispatch
    typedef struct packed {
        logic      valid;
        phys_reg_t rs1_phys;
        phys_reg_t rs2_phys;
        phys_reg_t rd_phys;
        phys_reg_t old_rd_phys;
    } rename_res_t;

    // latest earlier writer in the bundle for one operand
    typedef struct packed {
        logic  hit;
        slot_t slot;
    } bypass_sel_t;

    typedef struct packed {
        bypass_sel_t rs1;
        bypass_sel_t rs2;
        bypass_sel_t old_rd;
    } dep_sel_t;

    // register handed back by retire
    typedef struct packed {
        logic      valid;
        phys_reg_t phys;
    } release_t;

endpackage

`default_nettype wire

//--- source/rename_control.sv
// load enable, stall and allocation count of the rename stage
`timescale 1ns/1ps
`default_nettype none

module rename_control
    import rename_cfg_pkg::*;
    import rename_bundle_pkg::*;
#(
    parameter int unsigned BUNDLE_WIDTH = rename_cfg_pkg::BUNDLE_WIDTH
)
(
    input  wire rename_req_t [BUNDLE_WIDTH-1:0] req_i,
    input  wire free_count_t                    free_count_i,
    input  wire                                 advance_i,
    output logic                                load_o,
    output logic                                stall_o,
    output free_count_t                         alloc_count_o
);

    free_count_t writer_count;

    // every valid writer needs one free register
    always_comb
    begin
        writer_count = '0;
        for (int i = 0; i < BUNDLE_WIDTH; i++)
        begin
            if (req_i[i].valid && req_i[i].write_rd)
            begin
                writer_count = writer_count + free_count_t'(1);
            end
        end
    end

    // hold the whole bundle when the free list cannot cover it
    assign stall_o       = free_count_i < writer_count;
    assign load_o        = advance_i && !stall_o;
    assign alloc_count_o = writer_count;

endmodule

`default_nettype wire

//--- source/spec_rat.sv
// speculative rename table with per-slot reads and ordered writes
`timescale 1ns/1ps
`default_nettype none

module spec_rat
    import rename_cfg_pkg::*;
    import rename_bundle_pkg::*;
#(
    parameter int unsigned BUNDLE_WIDTH = rename_cfg_pkg::BUNDLE_WIDTH
)
(
    input  wire                                 clock,
    input  wire                                 reset_n,
    input  wire rename_req_t [BUNDLE_WIDTH-1:0] req_i,
    input  wire                                 load_i,
    input  wire phys_reg_t   [BUNDLE_WIDTH-1:0] alloc_i,
    output phys_reg_t        [BUNDLE_WIDTH-1:0] rs1_phys_o,
    output phys_reg_t        [BUNDLE_WIDTH-1:0] rs2_phys_o,
    output phys_reg_t        [BUNDLE_WIDTH-1:0] old_rd_phys_o
);

    phys_reg_t map_q [NUM_ARCH_REGS];

    // table values before this bundle, override fixes them later
    always_comb
    begin
        for (int i = 0; i < BUNDLE_WIDTH; i++)
        begin
            rs1_phys_o[i]    = map_q[req_i[i].rs1];
            rs2_phys_o[i]    = map_q[req_i[i].rs2];
            old_rd_phys_o[i] = map_q[req_i[i].rd];
        end
    end

    always_ff @(posedge clock or negedge reset_n)
    begin
        if (!reset_n)
        begin
            // identity mapping
            for (int a = 0; a < NUM_ARCH_REGS; a++)
            begin
                map_q[a] <= phys_reg_t'(a);
            end
        end
        else if (load_i)
        begin
            // later slots come last, so the youngest writer of rd wins
            for (int i = 0; i < BUNDLE_WIDTH; i++)
            begin
                if (req_i[i].valid && req_i[i].write_rd)
                begin
                    map_q[req_i[i].rd] <= alloc_i[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/free_list.sv
// circular free register queue with bundle allocation and retire release
`timescale 1ns/1ps
`default_nettype none

module free_list
    import rename_cfg_pkg::*;
    import rename_bundle_pkg::*;
#(
    parameter int unsigned BUNDLE_WIDTH  = rename_cfg_pkg::BUNDLE_WIDTH,
    parameter int unsigned RELEASE_WIDTH = rename_cfg_pkg::RELEASE_WIDTH,
    parameter int unsigned NUM_PHYS_REGS = rename_cfg_pkg::NUM_PHYS_REGS
)
(
    input  wire                                  clock,
    input  wire                                  reset_n,
    input  wire                                  load_i,
    input  wire rename_req_t [BUNDLE_WIDTH-1:0]  req_i,
    input  wire free_count_t                     alloc_count_i,
    input  wire release_t    [RELEASE_WIDTH-1:0] release_i,
    output phys_reg_t        [BUNDLE_WIDTH-1:0]  alloc_o,
    output free_count_t                          free_count_o
);

    localparam int unsigned PTR_W     = $clog2(NUM_PHYS_REGS);
    // everything above the architectural registers starts free
    localparam int unsigned INIT_FREE = NUM_PHYS_REGS - NUM_ARCH_REGS;

    typedef logic [PTR_W-1:0] ptr_t;

    phys_reg_t                   queue_q [NUM_PHYS_REGS];
    ptr_t                        head_q;
    ptr_t                        tail_q;
    ptr_t                        tail_d;
    free_count_t                 count_q;
    free_count_t                 rel_count;
    phys_reg_t [BUNDLE_WIDTH-1:0] peek;
    ptr_t      [RELEASE_WIDTH-1:0] rel_ptr;

    function automatic ptr_t ptr_add(ptr_t ptr, int unsigned inc);
        int unsigned sum;
        sum = ptr + inc;
        if (sum >= NUM_PHYS_REGS)
        begin
            sum = sum - NUM_PHYS_REGS;
        end
        return ptr_t'(sum);
    endfunction

////////////////////////////////////////
// allocation side

    always_comb
    begin
        for (int k = 0; k < BUNDLE_WIDTH; k++)
        begin
            peek[k] = queue_q[ptr_add(head_q, k)];
        end
    end

    // writers take the presented registers in slot order, others skip none
    always_comb
    begin : slot_order
        int unsigned taken;
        taken = 0;
        for (int i = 0; i < BUNDLE_WIDTH; i++)
        begin
            alloc_o[i] = peek[taken];
            if (req_i[i].valid && req_i[i].write_rd)
            begin
                taken = taken + 1;
            end
        end
    end

////////////////////////////////////////
// release side

    // port 0 is appended before port 1
    always_comb
    begin
        tail_d    = tail_q;
        rel_count = '0;
        for (int r = 0; r < RELEASE_WIDTH; r++)
        begin
            rel_ptr[r] = tail_d;
            if (release_i[r].valid)
            begin
                tail_d    = ptr_add(tail_d, 1);
                rel_count = rel_count + free_count_t'(1);
            end
        end
    end

    always_ff @(posedge clock or negedge reset_n)
    begin
        if (!reset_n)
        begin
            for (int e = 0; e < NUM_PHYS_REGS; e++)
            begin
                queue_q[e] <= (e < INIT_FREE) ? phys_reg_t'(NUM_ARCH_REGS + e) : '0;
            end
            head_q  <= '0;
            tail_q  <= ptr_t'(INIT_FREE);
            count_q <= free_count_t'(INIT_FREE);
        end
        else
        begin
            // releases go in every cycle, the head only moves on load
            for (int r = 0; r < RELEASE_WIDTH; r++)
            begin
                if (release_i[r].valid)
                begin
                    queue_q[rel_ptr[r]] <= release_i[r].phys;
                end
            end
            tail_q <= tail_d;
            if (load_i)
            begin
                head_q  <= ptr_add(head_q, alloc_count_i);
                count_q <= count_q - alloc_count_i + rel_count;
            end
            else
            begin
                count_q <= count_q + rel_count;
            end
        end
    end

    assign free_count_o = count_q;

endmodule

`default_nettype wire

//--- source/dep_check.sv
// intra-bundle dependency check against earlier writers
`timescale 1ns/1ps
`default_nettype none

module dep_check
    import rename_cfg_pkg::*;
    import rename_bundle_pkg::*;
#(
    parameter int unsigned BUNDLE_WIDTH = rename_cfg_pkg::BUNDLE_WIDTH
)
(
    input  wire rename_req_t [BUNDLE_WIDTH-1:0] req_i,
    output dep_sel_t         [BUNDLE_WIDTH-1:0] sel_o
);

    // a match with a younger writer replaces any older one
    function automatic bypass_sel_t track_writer(bypass_sel_t prev, arch_reg_t operand,
                                                 arch_reg_t writer_rd, int unsigned slot);
        bypass_sel_t sel;
        sel = prev;
        if (writer_rd == operand)
        begin
            sel.hit  = 1'b1;
            sel.slot = slot_t'(slot);
        end
        return sel;
    endfunction

    always_comb
    begin
        for (int i = 0; i < BUNDLE_WIDTH; i++)
        begin
            sel_o[i] = '0;
            // slot 0 has nobody ahead of it
            for (int j = 0; j < i; j++)
            begin
                if (req_i[j].valid && req_i[j].write_rd)
                begin
                    sel_o[i].rs1    = track_writer(sel_o[i].rs1, req_i[i].rs1,
                                                   req_i[j].rd, j);
                    sel_o[i].rs2    = track_writer(sel_o[i].rs2, req_i[i].rs2,
                                                   req_i[j].rd, j);
                    sel_o[i].old_rd = track_writer(sel_o[i].old_rd, req_i[i].rd,
                                                   req_i[j].rd, j);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/override_stage.sv
// stage-one register, override mux and result register toward dispatch
`timescale 1ns/1ps
`default_nettype none

module override_stage
    import rename_cfg_pkg::*;
    import rename_bundle_pkg::*;
#(
    parameter int unsigned BUNDLE_WIDTH = rename_cfg_pkg::BUNDLE_WIDTH
)
(
    input  wire                                 clock,
    input  wire                                 reset_n,
    input  wire                                 load_i,
    input  wire rename_req_t [BUNDLE_WIDTH-1:0] req_i,
    input  wire dep_sel_t    [BUNDLE_WIDTH-1:0] sel_i,
    input  wire phys_reg_t   [BUNDLE_WIDTH-1:0] rs1_phys_i,
    input  wire phys_reg_t   [BUNDLE_WIDTH-1:0] rs2_phys_i,
    input  wire phys_reg_t   [BUNDLE_WIDTH-1:0] old_rd_phys_i,
    input  wire phys_reg_t   [BUNDLE_WIDTH-1:0] alloc_i,
    output rename_res_t      [BUNDLE_WIDTH-1:0] res_o
);

    logic        [BUNDLE_WIDTH-1:0] valid_q;
    logic        [BUNDLE_WIDTH-1:0] write_q;
    dep_sel_t    [BUNDLE_WIDTH-1:0] sel_q;
    phys_reg_t   [BUNDLE_WIDTH-1:0] rs1_q;
    phys_reg_t   [BUNDLE_WIDTH-1:0] rs2_q;
    phys_reg_t   [BUNDLE_WIDTH-1:0] old_rd_q;
    phys_reg_t   [BUNDLE_WIDTH-1:0] alloc_q;
    rename_res_t [BUNDLE_WIDTH-1:0] res_d;

////////////////////////////////////////
// stage one

    always_ff @(posedge clock or negedge reset_n)
    begin
        if (!reset_n)
        begin
            valid_q <= '0;
        end
        else if (load_i)
        begin
            for (int i = 0; i < BUNDLE_WIDTH; i++)
            begin
                valid_q[i] <= req_i[i].valid;
            end
        end
    end

    always_ff @(posedge clock)
    begin
        if (load_i)
        begin
            for (int i = 0; i < BUNDLE_WIDTH; i++)
            begin
                write_q[i] <= req_i[i].write_rd;
            end
            sel_q    <= sel_i;
            rs1_q    <= rs1_phys_i;
            rs2_q    <= rs2_phys_i;
            old_rd_q <= old_rd_phys_i;
            alloc_q  <= alloc_i;
        end
    end

    // an earlier writer in the bundle beats the stale table entry
    always_comb
    begin
        for (int i = 0; i < BUNDLE_WIDTH; i++)
        begin
            res_d[i] = '0;
            if (valid_q[i])
            begin
                res_d[i].valid       = 1'b1;
                res_d[i].rs1_phys    = sel_q[i].rs1.hit ? alloc_q[sel_q[i].rs1.slot] : rs1_q[i];
                res_d[i].rs2_phys    = sel_q[i].rs2.hit ? alloc_q[sel_q[i].rs2.slot] : rs2_q[i];
                res_d[i].old_rd_phys = sel_q[i].old_rd.hit ? alloc_q[sel_q[i].old_rd.slot]
                                                           : old_rd_q[i];
                res_d[i].rd_phys     = write_q[i] ? alloc_q[i] : '0;
            end
        end
    end

////////////////////////////////////////
// toward dispatch

    always_ff @(posedge clock or negedge reset_n)
    begin
        if (!reset_n)
        begin
            res_o <= '0;
        end
        else if (load_i)
        begin
            res_o <= res_d;
        end
    end

endmodule

`default_nettype wire

//--- source/rename_top.sv
// rename stage top level with control, table, free list and override
`timescale 1ns/1ps
`default_nettype none

module rename_top
    import rename_cfg_pkg::*;
    import rename_bundle_pkg::*;
#(
    parameter int unsigned BUNDLE_WIDTH  = rename_cfg_pkg::BUNDLE_WIDTH,
    parameter int unsigned RELEASE_WIDTH = rename_cfg_pkg::RELEASE_WIDTH,
    parameter int unsigned NUM_PHYS_REGS = rename_cfg_pkg::NUM_PHYS_REGS
)
(
    input  wire                                  clock,
    input  wire                                  reset_n,
    input  wire rename_req_t [BUNDLE_WIDTH-1:0]  req_i,
    input  wire                                  advance_i,
    input  wire release_t    [RELEASE_WIDTH-1:0] release_i,
    output wire rename_res_t [BUNDLE_WIDTH-1:0]  res_o,
    output wire                                  stall_o
);

    logic                          load;
    free_count_t                   free_count;
    free_count_t                   alloc_count;
    phys_reg_t [BUNDLE_WIDTH-1:0]  alloc;
    phys_reg_t [BUNDLE_WIDTH-1:0]  rs1_phys;
    phys_reg_t [BUNDLE_WIDTH-1:0]  rs2_phys;
    phys_reg_t [BUNDLE_WIDTH-1:0]  old_rd_phys;
    dep_sel_t  [BUNDLE_WIDTH-1:0]  sel;

////////////////////////////////////////
// control

    rename_control #(
        .BUNDLE_WIDTH (BUNDLE_WIDTH)
    ) rename_control_inst (
        .req_i         (req_i),
        .free_count_i  (free_count),
        .advance_i     (advance_i),
        .load_o        (load),
        .stall_o       (stall_o),
        .alloc_count_o (alloc_count)
    );

////////////////////////////////////////
// stage zero

    spec_rat #(
        .BUNDLE_WIDTH (BUNDLE_WIDTH)
    ) spec_rat_inst (
        .clock         (clock),
        .reset_n       (reset_n),
        .req_i         (req_i),
        .load_i        (load),
        .alloc_i       (alloc),
        .rs1_phys_o    (rs1_phys),
        .rs2_phys_o    (rs2_phys),
        .old_rd_phys_o (old_rd_phys)
    );

    free_list #(
        .BUNDLE_WIDTH  (BUNDLE_WIDTH),
        .RELEASE_WIDTH (RELEASE_WIDTH),
        .NUM_PHYS_REGS (NUM_PHYS_REGS)
    ) free_list_inst (
        .clock         (clock),
        .reset_n       (reset_n),
        .load_i        (load),
        .req_i         (req_i),
        .alloc_count_i (alloc_count),
        .release_i     (release_i),
        .alloc_o       (alloc),
        .free_count_o  (free_count)
    );

    dep_check #(
        .BUNDLE_WIDTH (BUNDLE_WIDTH)
    ) dep_check_inst (
        .req_i (req_i),
        .sel_o (sel)
    );

////////////////////////////////////////
// stage one and output

    override_stage #(
        .BUNDLE_WIDTH (BUNDLE_WIDTH)
    ) override_stage_inst (
        .clock         (clock),
        .reset_n       (reset_n),
        .load_i        (load),
        .req_i         (req_i),
        .sel_i         (sel),
        .rs1_phys_i    (rs1_phys),
        .rs2_phys_i    (rs2_phys),
        .old_rd_phys_i (old_rd_phys),
        .alloc_i       (alloc),
        .res_o         (res_o)
    );

endmodule

`default_nettype wire

//--- testbench/rename_model.svh
// reference model of the rename table, the free queue and the retired registers
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

phys_reg_t model_map [NUM_ARCH_REGS];
phys_reg_t model_free [$];
// old mappings of accepted writers, waiting for retire
phys_reg_t model_retired [$];

function automatic void model_reset();
    model_free.delete();
    model_retired.delete();
    for (int a = 0; a < NUM_ARCH_REGS; a++)
    begin
        model_map[a] = phys_reg_t'(a);
    end
    for (int p = NUM_ARCH_REGS; p < NUM_PHYS_REGS; p++)
    begin
        model_free.push_back(phys_reg_t'(p));
    end
endfunction

function automatic int count_writers(input req_bundle_t b);
    int n;
    n = 0;
    for (int i = 0; i < BUNDLE_WIDTH; i++)
    begin
        if (b[i].valid && b[i].write_rd)
        begin
            n++;
        end
    end
    return n;
endfunction

// slots in order against a live table, so earlier writers are seen by later slots
function automatic res_bundle_t model_rename(input req_bundle_t b);
    res_bundle_t out;
    out = '0;
    for (int i = 0; i < BUNDLE_WIDTH; i++)
    begin
        if (b[i].valid)
        begin
            out[i].valid       = 1'b1;
            out[i].rs1_phys    = model_map[b[i].rs1];
            out[i].rs2_phys    = model_map[b[i].rs2];
            out[i].old_rd_phys = model_map[b[i].rd];
            if (b[i].write_rd)
            begin
                out[i].rd_phys     = model_free.pop_front();
                model_map[b[i].rd] = out[i].rd_phys;
                model_retired.push_back(out[i].old_rd_phys);
            end
        end
    end
    return out;
endfunction

function automatic void model_release(input rel_bundle_t r);
    for (int p = 0; p < RELEASE_WIDTH; p++)
    begin
        if (r[p].valid)
        begin
            model_free.push_back(r[p].phys);
        end
    end
endfunction

`endif

//--- testbench/rename_top_tb.sv
// testbench for the rename stage with reference model, random stream and checks
`timescale 1ns/1ps
`default_nettype none

module rename_top_tb
    import rename_cfg_pkg::*;
    import rename_bundle_pkg::*;
;

    typedef rename_req_t [BUNDLE_WIDTH-1:0]  req_bundle_t;
    typedef release_t    [RELEASE_WIDTH-1:0] rel_bundle_t;
    typedef rename_res_t [BUNDLE_WIDTH-1:0]  res_bundle_t;

    logic        clock;
    logic        reset_n;
    req_bundle_t req_in;
    logic        advance_in;
    rel_bundle_t rel_in;
    res_bundle_t res_out;
    wire         stall_out;

    string       test_name;
    logic [31:0] lcg_state;
    logic        last_stall;
    int          accept_count;
    res_bundle_t expected_out;
    res_bundle_t exp_q [$];

    `include "rename_model.svh"

    rename_top rename_top_inst (
        .clock     (clock),
        .reset_n   (reset_n),
        .req_i     (req_in),
        .advance_i (advance_in),
        .release_i (rel_in),
        .res_o     (res_out),
        .stall_o   (stall_out)
    );

    initial
    begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic raise_error(input string line);
        $display("%s", line);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic rename_req_t instr(input arch_reg_t rs1, input arch_reg_t rs2,
                                          input arch_reg_t rd, input logic write_rd);
        rename_req_t r;
        r.valid    = 1'b1;
        r.rs1      = rs1;
        r.rs2      = rs2;
        r.rd       = rd;
        r.write_rd = write_rd;
        return r;
    endfunction

    function automatic req_bundle_t random_bundle();
        req_bundle_t b;
        logic [31:0] r;
        for (int i = 0; i < BUNDLE_WIDTH; i++)
        begin
            r          = next_random();
            b[i].valid = r[31] | r[30];
            b[i].write_rd = r[29] | r[28];
            b[i].rs1   = r[27:23];
            b[i].rs2   = r[22:18];
            b[i].rd    = r[17:13];
        end
        return b;
    endfunction

    // one clock cycle: drive, check the stall prediction, then advance the model
    task automatic run_cycle(input req_bundle_t b, input logic adv, input rel_bundle_t rel);
        logic pred_stall;
        logic accept;
        pred_stall = count_writers(b) > model_free.size();
        accept     = adv && !pred_stall;
        req_in     = b;
        advance_in = adv;
        rel_in     = rel;
        @(negedge clock);
        last_stall = stall_out;
        assert (stall_out == pred_stall)
        else
        begin
            raise_error($sformatf("** Error [%s] stall_o expected %0b actual %0b",
                                  test_name, pred_stall, stall_out));
        end
        @(posedge clock);
        if (accept)
        begin
            exp_q.push_back(model_rename(b));
            expected_out = exp_q.pop_front();
            accept_count++;
        end
        model_release(rel);
        #1;
    endtask

    // idle loads until the last accepted bundle reaches res_o
    task automatic drain_bundle(input int limit);
        int target;
        int waited;
        target = accept_count + 1;
        waited = 0;
        while (accept_count < target)
        begin
            if (waited == limit)
            begin
                raise_error($sformatf("[%s] timeout, no load happened while draining",
                                      test_name));
            end
            run_cycle('0, 1'b1, '0);
            waited++;
        end
    endtask

    // res_o against the model, every cycle, so holds are covered too
    always @(negedge clock)
    begin
        if (reset_n)
        begin
            assert (res_out == expected_out)
            else
            begin
                raise_error($sformatf("** Error [%s] res_o expected %h actual %h",
                                      test_name, expected_out, res_out));
            end
        end
    end

    initial
    begin
        req_bundle_t b;
        req_bundle_t full;
        rel_bundle_t rel;
        res_bundle_t held;
        rename_res_t want;
        phys_reg_t   first_rel;
        logic [31:0] r;
        int          waited;

        req_in       = '0;
        advance_in   = 1'b0;
        rel_in       = '0;
        reset_n      = 1'b0;
        lcg_state    = 32'd91;
        last_stall   = 1'b0;
        accept_count = 0;
        expected_out = '0;
        test_name    = "reset";
        model_reset();
        // stage one is empty after reset
        exp_q.push_back('0);
        repeat (8) @(posedge clock);
        #1 reset_n = 1'b1;

        @(negedge clock);
        assert (res_out == '0 && stall_out == 1'b0)
        else
        begin
            raise_error($sformatf("** Error [%s] res_o/stall_o expected 0/0 actual %h/%0b",
                                  test_name, res_out, stall_out));
        end
        @(posedge clock);
        #1;

        ////////////////////////////////////////
        test_name = "single instruction";
        b    = '0;
        b[0] = instr(5'd3, 5'd4, 5'd5, 1'b1);
        run_cycle(b, 1'b1, '0);
        drain_bundle(10);
        want = '{valid: 1'b1, rs1_phys: 7'd3, rs2_phys: 7'd4,
                 rd_phys: 7'd32, old_rd_phys: 7'd5};
        assert (res_out[0] == want)
        else
        begin
            raise_error($sformatf("** Error [%s] slot 0 expected %h actual %h",
                                  test_name, want, res_out[0]));
        end

        ////////////////////////////////////////
        test_name = "bundle dependencies";
        b[0] = instr(5'd1, 5'd2, 5'd6, 1'b1);
        b[1] = instr(5'd6, 5'd7, 5'd8, 1'b1);
        b[2] = instr(5'd9, 5'd6, 5'd10, 1'b1);
        b[3] = instr(5'd10, 5'd11, 5'd10, 1'b1);
        run_cycle(b, 1'b1, '0);
        drain_bundle(10);
        assert (res_out[1].rs1_phys == 7'd33)
        else
        begin
            raise_error($sformatf("** Error [%s] slot 1 rs1_phys expected %0d actual %0d",
                                  test_name, 7'd33, res_out[1].rs1_phys));
        end
        want = '{valid: 1'b1, rs1_phys: 7'd35, rs2_phys: 7'd11,
                 rd_phys: 7'd36, old_rd_phys: 7'd35};
        assert (res_out[3] == want)
        else
        begin
            raise_error($sformatf("** Error [%s] slot 3 expected %h actual %h",
                                  test_name, want, res_out[3]));
        end

        ////////////////////////////////////////
        test_name = "exhaustion";
        for (int i = 0; i < BUNDLE_WIDTH; i++)
        begin
            full[i] = instr(5'd1, 5'd2, arch_reg_t'(12 + i), 1'b1);
        end
        waited = 0;
        while (!last_stall)
        begin
            if (waited == 30)
            begin
                raise_error("[exhaustion] timeout, stall_o never rose");
            end
            run_cycle(full, 1'b1, '0);
            waited++;
        end
        // model result of the last load before the stall
        held = expected_out;
        repeat (3) run_cycle(full, 1'b1, '0);
        assert (res_out == held)
        else
        begin
            raise_error($sformatf("** Error [%s] held res_o expected %h actual %h",
                                  test_name, held, res_out));
        end
        first_rel = model_retired[0];
        waited    = 0;
        while (last_stall)
        begin
            if (waited == 10)
            begin
                raise_error("[exhaustion] timeout, stall_o stayed high after releases");
            end
            rel = '0;
            for (int p = 0; p < RELEASE_WIDTH; p++)
            begin
                rel[p].valid = 1'b1;
                rel[p].phys  = model_retired.pop_front();
            end
            run_cycle(full, 1'b1, rel);
            waited++;
        end
        drain_bundle(10);
        // three old free registers go first, the first released one follows
        assert (res_out[3].rd_phys == first_rel)
        else
        begin
            raise_error($sformatf("** Error [%s] slot 3 rd_phys expected %0d actual %0d",
                                  test_name, first_rel, res_out[3].rd_phys));
        end

        ////////////////////////////////////////
        test_name = "random stream";
        for (int c = 0; c < 300; c++)
        begin
            b   = random_bundle();
            r   = next_random();
            rel = '0;
            for (int p = 0; p < RELEASE_WIDTH; p++)
            begin
                if (r[20 + p] && model_retired.size() > 0)
                begin
                    rel[p].valid = 1'b1;
                    rel[p].phys  = model_retired.pop_front();
                end
            end
            run_cycle(b, r[31] | r[30], rel);
        end
        drain_bundle(20);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- rename_top.f
+incdir+testbench
source/rename_cfg_pkg.sv
source/rename_bundle_pkg.sv
source/rename_control.sv
source/spec_rat.sv
source/free_list.sv
source/dep_check.sv
source/override_stage.sv
source/rename_top.sv
testbench/rename_top_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f rename_top.f \
    --top-module rename_top_tb \
    -o rename_top_sim

./obj_dir/rename_top_sim
